// ==== common/crc24_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// crc24 configuration
// word width, CRC width, generator polynomial and seed for the burst
// CRC24 engine
//////////////////////////////////////////////////////////////////////

`ifndef CRC24_CFG_SVH
`define CRC24_CFG_SVH

// one data word is accepted per enabled cycle
`define CRC24_WORD_W 64

// width of the CRC state and of the result
`define CRC24_W 24

// generator polynomial, x^24 term implied
`define CRC24_POLY 24'h328B63

// every burst starts from the all ones state
`define CRC24_SEED 24'hFFFFFF

`endif

// ==== common/crc24_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// crc24 package
// CRC and word types plus the two XOR-network functions shared by
// the linear word reduction and the combiner
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "crc24_cfg.svh"

package crc24_pkg;

	// running CRC state
	typedef logic [`CRC24_W-1:0] crc_t;

	// one data word of a burst
	typedef logic [`CRC24_WORD_W-1:0] word_t;

	// number of earlier words a word covers
	// only 0 (sop, reseed) and 1 (chain on previous result) are legal
	typedef logic [3:0] covered_t;

	//////////////////////////////////////////////////////////////////////
	// linear contribution of one word
	//////////////////////////////////////////////////////////////////////

	// the CRC of a word starting from the zero state
	// bits go in most significant first, one LFSR step per bit
	// the loop unrolls into a flat 64 to 24 XOR network
	function automatic crc_t crc_lin(input word_t d);
		crc_t c;
		logic fb;
		c = '0;
		for (int i = `CRC24_WORD_W - 1; i >= 0; i--) begin
			fb = c[`CRC24_W-1] ^ d[i];
			c = {c[`CRC24_W-2:0], 1'b0};
			if (fb) begin
				c = c ^ `CRC24_POLY;
			end
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// zero evolution
	//////////////////////////////////////////////////////////////////////

	// advance a state through one word of zero bits
	// because the CRC is affine, the CRC of a longer message is this
	// evolved state XOR the linear contribution of the new word
	function automatic crc_t crc_zer64(input crc_t s);
		crc_t c;
		logic fb;
		c = s;
		for (int i = 0; i < `CRC24_WORD_W; i++) begin
			// data bit is zero so only the top state bit feeds back
			fb = c[`CRC24_W-1];
			c = {c[`CRC24_W-2:0], 1'b0};
			if (fb) begin
				c = c ^ `CRC24_POLY;
			end
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/crc24_burst_top.sv ====
//////////////////////////////////////////////////////////////////////
// crc24 burst engine top
// runs the word reduction and the framing control side by side and
// joins them in the combiner
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module crc24_burst_top (
	input  wire logic             clk,
	input  wire logic             arst,
	input  wire logic             ena,
	input  wire crc24_pkg::word_t data,
	input  wire logic             valid,
	input  wire logic             sop,
	input  wire logic             eop,
	output crc24_pkg::crc_t       crc,
	output logic                  crc_done,
	output logic                  frame_err
);

	import crc24_pkg::*;

	// stage 1 results, all one enabled cycle behind the inputs
	crc_t     lin_crc;
	covered_t covered;
	logic     word_valid;
	logic     last_word;

	// data path, the heavy XOR reduction
	crc24_word_lin u_word_lin (
		.clk     (clk),
		.arst    (arst),
		.ena     (ena),
		.data    (data),
		.valid   (valid),
		.lin_crc (lin_crc)
	);

	// framing path, runs in parallel with the reduction
	crc24_span_ctl u_span_ctl (
		.clk        (clk),
		.arst       (arst),
		.ena        (ena),
		.valid      (valid),
		.sop        (sop),
		.eop        (eop),
		.covered    (covered),
		.word_valid (word_valid),
		.last_word  (last_word),
		.frame_err  (frame_err)
	);

	// final stage, result lands two enabled cycles after a word
	crc24_combine u_combine (
		.clk        (clk),
		.arst       (arst),
		.ena        (ena),
		.lin_crc    (lin_crc),
		.covered    (covered),
		.word_valid (word_valid),
		.last_word  (last_word),
		.crc        (crc),
		.crc_done   (crc_done)
	);

endmodule

`default_nettype wire

// ==== hdl/crc24_combine.sv ====
//////////////////////////////////////////////////////////////////////
// crc24 combiner
// joins the evolved seed or the previous CRC with the contribution of
// the current word and marks finished bursts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "crc24_cfg.svh"

module crc24_combine (
	input  wire logic               clk,
	input  wire logic               arst,
	input  wire logic               ena,
	input  wire crc24_pkg::crc_t    lin_crc,
	input  wire crc24_pkg::covered_t covered,
	input  wire logic               word_valid,
	input  wire logic               last_word,
	output crc24_pkg::crc_t         crc,
	output logic                    crc_done
);

	import crc24_pkg::*;

	// the seed advanced over one word is a constant
	localparam crc_t SEED_EVO = crc_zer64(`CRC24_SEED);

	// contribution and its framing delayed by one more enabled cycle
	crc_t     lin_r;
	covered_t covered_r;
	logic     word_valid_r;
	logic     last_word_r;

	// evolved start state picked by the covered count
	crc_t evo_sel;

	//////////////////////////////////////////////////////////////////////
	// alignment stage
	//////////////////////////////////////////////////////////////////////

	// contribution of the word now in the alignment stage
	always_ff @(posedge clk) begin
		if (ena) begin
			lin_r <= lin_crc;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			covered_r    <= '0;
			word_valid_r <= 1'b0;
			last_word_r  <= 1'b0;
		end else if (ena) begin
			covered_r    <= covered;
			word_valid_r <= word_valid;
			last_word_r  <= last_word;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// combine
	//////////////////////////////////////////////////////////////////////

	// crc already holds the previous word's result at the edge where
	// this word loads, so chaining needs no extra forwarding
	always_comb begin
		case (covered_r)
			covered_t'(0): evo_sel = SEED_EVO;
			covered_t'(1): evo_sel = crc_zer64(crc);
			default:       evo_sel = '0;
		endcase
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			crc <= `CRC24_SEED;
		end else if (ena && word_valid_r) begin
			crc <= evo_sel ^ lin_r;
		end
	end

	// done is a single-cycle event that a stalled cycle does not repeat
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			crc_done <= 1'b0;
		end else begin
			crc_done <= ena && word_valid_r && last_word_r;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// the evolution select only has paths for 0 and 1 earlier words
	a_covered_range : assert property (
		@(posedge clk) disable iff (arst)
		covered <= covered_t'(1)
	);

	// the framing control must only mark a last word on a valid word
	// so that every crc_done follows a word that was really loaded
	a_done_after_valid : assert property (
		@(posedge clk) disable iff (arst)
		last_word |-> word_valid
	);

endmodule

`default_nettype wire

// ==== hdl/crc24_span_ctl.sv ====
//////////////////////////////////////////////////////////////////////
// crc24 burst framing control
// tracks sop/eop framing, decides how many earlier words each word
// covers and flags framing errors
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module crc24_span_ctl (
	input  wire logic            clk,
	input  wire logic            arst,
	input  wire logic            ena,
	input  wire logic            valid,
	input  wire logic            sop,
	input  wire logic            eop,
	output crc24_pkg::covered_t  covered,
	output logic                 word_valid,
	output logic                 last_word,
	output logic                 frame_err
);

	import crc24_pkg::*;

	// set between an accepted sop and the matching eop
	logic in_burst;

	// a word is only looked at when the pipeline advances
	logic accept;

	// count of earlier words for the word now at the inputs
	covered_t covered_nxt;

	// misframe conditions for the word now at the inputs
	logic err_nxt;

	assign accept = ena && valid;

	// only a well-placed sop reseeds
	// a sop inside a burst and a stray word outside one both chain on
	// the previous result, so the CRC keeps advancing over them
	assign covered_nxt = (sop && !in_burst) ? covered_t'(0) : covered_t'(1);

	assign err_nxt = accept && ((sop && in_burst) || (!sop && !in_burst));

	//////////////////////////////////////////////////////////////////////
	// framing state
	//////////////////////////////////////////////////////////////////////

	// eop wins over sop so a single-word burst leaves the state idle
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			in_burst <= 1'b0;
		end else if (accept) begin
			if (eop) begin
				in_burst <= 1'b0;
			end else if (sop) begin
				in_burst <= 1'b1;
			end
		end
	end

	// the outputs to the combiner lag the inputs by one enabled cycle
	// which lines them up with lin_crc from the word reduction
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			covered    <= '0;
			word_valid <= 1'b0;
			last_word  <= 1'b0;
		end else if (ena) begin
			covered    <= valid ? covered_nxt : covered_t'(0);
			word_valid <= valid;
			last_word  <= valid && eop;
		end
	end

	// the error flag is a single-cycle event and drops again on a stalled cycle
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			frame_err <= 1'b0;
		end else begin
			frame_err <= err_nxt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// unknown framing bits on an accepted word would turn the burst state
	// and every later covered count into X
	a_framing_known : assert property (
		@(posedge clk) disable iff (arst)
		accept |-> !$isunknown({sop, eop})
	);

endmodule

`default_nettype wire

// ==== hdl/crc24_word_lin.sv ====
//////////////////////////////////////////////////////////////////////
// crc24 word reduction
// registers the zero-state CRC of each accepted data word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module crc24_word_lin (
	input  wire logic             clk,
	input  wire logic             arst,
	input  wire logic             ena,
	input  wire crc24_pkg::word_t data,
	input  wire logic             valid,
	output crc24_pkg::crc_t       lin_crc
);

	import crc24_pkg::*;

	// combinational reduction of the incoming word
	// this is the wide part of the datapath, 64 inputs folded to 24
	crc_t lin_nxt;

	assign lin_nxt = crc_lin(data);

	// capture only words that are really accepted
	// idle and stalled cycles leave the last contribution in place,
	// the combiner ignores it unless its own valid copy is set
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			lin_crc <= '0;
		end else if (ena && valid) begin
			lin_crc <= lin_nxt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// an X here would silently poison every later burst through the
	// combiner feedback, so catch it where it enters
	a_lin_known : assert property (
		@(posedge clk) disable iff (arst)
		!$isunknown(lin_crc)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -f sim.f --top-module tb_crc24_burst \
	-Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vtb_crc24_burst > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== sim.f ====
+incdir+common
common/crc24_pkg.sv
hdl/crc24_word_lin.sv
hdl/crc24_span_ctl.sv
hdl/crc24_combine.sv
hdl/crc24_burst_top.sv
sim/tb_clkgen.sv
sim/tb_crc24_burst.sv

// ==== sim/tb_clkgen.sv ====
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
// 10 ns clock, reset held high for the first three cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic arst
);

	localparam int HALF_PERIOD = 5;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release on a falling edge, well away from the sampling edge
	initial begin
		arst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/tb_crc24_burst.sv ====
//////////////////////////////////////////////////////////////////////
// crc24 burst engine testbench
// drives bursts into the engine, models the CRC bit by bit and checks
// results, framing errors and stall behavior with assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "crc24_cfg.svh"

module tb_crc24_burst;

	import crc24_pkg::*;

	logic  clk;
	logic  arst;
	logic  ena;
	word_t data;
	logic  valid;
	logic  sop;
	logic  eop;
	crc_t  crc;
	logic  crc_done;
	logic  frame_err;

	integer seed;
	string  test_name;
	// expected burst results in the order the bursts end
	crc_t   exp_q[$];
	int     n_exp = 0;
	int     n_done = 0;
	int     exp_ferr = 0;
	int     n_ferr = 0;
	int     err_cnt = 0;
	int     assert_err = 0;
	int     err_base;
	int     n_tests = 0;
	int     n_failed = 0;
	// model state that follows the framing rules of the interface
	crc_t   m_state;
	logic   m_in_burst;
	// test 3 keeps its bursts so test 4 can replay them
	int     burst_len[$];
	word_t  burst_word[$];

	tb_clkgen u_clkgen (
		.clk  (clk),
		.arst (arst)
	);

	crc24_burst_top u_dut (
		.clk       (clk),
		.arst      (arst),
		.ena       (ena),
		.data      (data),
		.valid     (valid),
		.sop       (sop),
		.eop       (eop),
		.crc       (crc),
		.crc_done  (crc_done),
		.frame_err (frame_err)
	);

	//////////////////////////////////////////////////////////////////////
	// monitors and assertions on the falling edge where outputs sit
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!arst && crc_done) begin
			n_done <= n_done + 1;
		end
		if (!arst && frame_err) begin
			n_ferr <= n_ferr + 1;
		end
	end

	a_crc_match : assert property (
		@(negedge clk) disable iff (arst)
		crc_done |-> (crc == exp_q[n_done])
	) else begin
		$display("[ERROR] %s expected %06h actual %06h", test_name,
			exp_q[$sampled(n_done)], crc);
		assert_err = assert_err + 1;
	end

	a_done_expected : assert property (
		@(negedge clk) disable iff (arst)
		crc_done |-> (n_done < n_exp)
	) else begin
		$display("crc_done pulsed in %s while no burst was outstanding", test_name);
		assert_err = assert_err + 1;
	end

	// a stalled edge must leave the result and the done flag alone
	a_stall_hold : assert property (
		@(negedge clk) disable iff (arst)
		!$past(ena) |-> ($stable(crc) && !crc_done)
	) else begin
		$display("crc moved or crc_done rose across a stalled edge in %s", test_name);
		assert_err = assert_err + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// shift one word through the LFSR with the most significant bit first
	function automatic crc_t serial_crc(input crc_t s, input word_t d);
		crc_t c;
		logic fb;
		c = s;
		for (int i = `CRC24_WORD_W - 1; i >= 0; i--) begin
			fb = c[`CRC24_W-1] ^ d[i];
			c = {c[`CRC24_W-2:0], 1'b0};
			if (fb) begin
				c = c ^ `CRC24_POLY;
			end
		end
		return c;
	endfunction

	// only a sop outside a burst restarts from the seed and anything
	// else keeps advancing the running state
	task automatic model_accept(input word_t d, input logic s, input logic e);
		if (s && !m_in_burst) begin
			m_state = `CRC24_SEED;
		end
		if ((s && m_in_burst) || (!s && !m_in_burst)) begin
			exp_ferr++;
		end
		m_state = serial_crc(m_state, d);
		if (e) begin
			exp_q.push_back(m_state);
			n_exp++;
			m_in_burst = 1'b0;
		end else if (s) begin
			m_in_burst = 1'b1;
		end
	endtask

	function automatic word_t rand_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic int total_err();
		return err_cnt + assert_err;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// hold the word on the inputs until an edge with ena high takes it
	task automatic drive_word(input word_t d, input logic s, input logic e, input bit gaps);
		bit en;
		int tries;
		en = 1'b0;
		tries = 0;
		while (!en && tries < 64) begin
			@(posedge clk);
			en = gaps ? (($random(seed) & 3) != 0) : 1'b1;
			if (tries == 63) begin
				en = 1'b1;
			end
			ena   <= en;
			valid <= 1'b1;
			data  <= d;
			sop   <= s;
			eop   <= e;
			tries++;
		end
		model_accept(d, s, e);
	endtask

	// idle cycles until every expected burst has come out
	task automatic flush(input bit gaps);
		int cyc;
		cyc = 0;
		while ((n_done < n_exp || cyc < 4) && cyc < 200) begin
			@(posedge clk);
			ena   <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
			valid <= 1'b0;
			sop   <= 1'b0;
			eop   <= 1'b0;
			cyc++;
		end
		if (n_done < n_exp) begin
			$display("timeout in %s, only %0d of %0d bursts finished", test_name, n_done, n_exp);
			err_cnt++;
		end
	endtask

	task automatic run_bursts(input bit gaps);
		int idx;
		idx = 0;
		foreach (burst_len[b]) begin
			for (int w = 0; w < burst_len[b]; w++) begin
				drive_word(burst_word[idx], w == 0, w == burst_len[b] - 1, gaps);
				idx++;
			end
		end
		flush(gaps);
	endtask

	task automatic test_begin(input string name);
		test_name = name;
		err_base = total_err();
	endtask

	task automatic test_end();
		assert (n_ferr == exp_ferr) else begin
			$display("[ERROR] %s expected %0d actual %0d frame_err pulses", test_name,
				exp_ferr, n_ferr);
			err_cnt++;
		end
		n_tests++;
		if (total_err() == err_base) begin
			$display("test %s finished ok", test_name);
		end else begin
			n_failed++;
			$display("test %s finished with %0d errors", test_name, total_err() - err_base);
		end
	endtask

	initial begin
		int guard;
		int lat;
		bit seen;
		int len;
		seed = 32'h148dac1d;
		ena = 1'b0;
		data = '0;
		valid = 1'b0;
		sop = 1'b0;
		eop = 1'b0;
		m_state = `CRC24_SEED;
		m_in_burst = 1'b0;
		guard = 0;
		while (arst && guard < 50) begin
			@(posedge clk);
			guard++;
		end
		if (arst) begin
			$display("reset was never released");
			err_cnt++;
		end

		// 1 idle engine after reset shows the seed and no events
		test_begin("reset");
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			ena   <= 1'b1;
			valid <= 1'b0;
			@(negedge clk);
			assert (crc == `CRC24_SEED && !crc_done && !frame_err) else begin
				$display("[ERROR] %s expected %06h/0/0 actual %06h/%0b/%0b", test_name,
					`CRC24_SEED, crc, crc_done, frame_err);
				err_cnt++;
			end
		end
		test_end();

		// 2 single-word burst whose done flag follows edge t+2 after acceptance
		test_begin("single_word");
		drive_word(rand_word(), 1'b1, 1'b1, 1'b0);
		@(posedge clk);
		valid <= 1'b0;
		sop   <= 1'b0;
		eop   <= 1'b0;
		lat = 0;
		seen = 1'b0;
		while (!seen && lat < 20) begin
			@(negedge clk);
			lat++;
			seen = crc_done;
		end
		if (!seen) begin
			$display("timeout in %s, crc_done never came", test_name);
			err_cnt++;
		end else begin
			assert (lat == 3) else begin
				$display("[ERROR] %s expected 3 actual %0d cycles to crc_done", test_name, lat);
				err_cnt++;
			end
		end
		flush(1'b0);
		test_end();

		// 3 back to back bursts of 2 to 8 words with no idle cycles between them
		test_begin("back_to_back");
		for (int b = 0; b < 6; b++) begin
			len = 2 + (($random(seed) & 32'h7fffffff) % 7);
			burst_len.push_back(len);
			for (int w = 0; w < len; w++) begin
				burst_word.push_back(rand_word());
			end
		end
		run_bursts(1'b0);
		test_end();

		// 4 same bursts again with the pipeline stalled at random
		test_begin("ena_gaps");
		run_bursts(1'b1);
		test_end();

		// 5 sop inside a burst, then a stray eop word, then a clean burst
		test_begin("framing");
		drive_word(rand_word(), 1'b1, 1'b0, 1'b0);
		drive_word(rand_word(), 1'b1, 1'b0, 1'b0);
		drive_word(rand_word(), 1'b0, 1'b1, 1'b0);
		drive_word(rand_word(), 1'b0, 1'b1, 1'b0);
		drive_word(rand_word(), 1'b1, 1'b0, 1'b0);
		drive_word(rand_word(), 1'b0, 1'b0, 1'b0);
		drive_word(rand_word(), 1'b0, 1'b1, 1'b0);
		flush(1'b0);
		test_end();

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_err());
		if (total_err() == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
